//--- files.f
+incdir+verif
logic/lspcPkg.sv
logic/pbusSequencer.sv
logic/vramAddrUnit.sv
logic/autoAnimTimer.sv
logic/spriteTileBuilder.sv
logic/pbusMux.sv
logic/lspcPbus.sv
verif/tbLspcPbus.sv

//--- Makefile
# Verilator simulation of the LSPC P-bus block
SIM      = verilator
FLAGS    = --binary --assert --timescale 1ns/1ps -j 0
TOP      = tbLspcPbus
FILELIST = files.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJDIR)

//--- verif/tbChecks.svh
// Compare tasks for the LSPC P-bus testbench
// One task per result kind, each keeps its own error count
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Error counts per result kind
int pbusErrors  = 0;
int driveErrors = 0;
int addrErrors  = 0;
int otherErrors = 0;

// Full 24-bit bus word, upper and lower part together
task automatic checkPbus(input pbusWord_t got, input pbusWord_t exp);
	if (got !== exp) begin
		$display("MISMATCH pbus at %0t: got %h expected %h", $time, got, exp);
		pbusErrors++;
	end
endtask

// Upper-byte drive enable
task automatic checkDrive(input logic got, input logic exp);
	if (got !== exp) begin
		$display("MISMATCH pbusDrive at %0t: got %h expected %h", $time, got, exp);
		driveErrors++;
	end
endtask

task automatic checkVramAddr(input vramAddr_t got, input vramAddr_t exp);
	if (got !== exp) begin
		$display("MISMATCH vramAddr at %0t: got %h expected %h", $time, got, exp);
		addrErrors++;
	end
endtask

`endif

//--- verif/tbLspcPbus.sv
// Testbench for the LSPC P-bus word assembly
// Random bus traffic from a fixed seed, checked each cycle against
// a cycle model of slots, VRAM address, modulo and auto-animation
`timescale 1ns/1ps
`default_nettype none

module tbLspcPbus import lspcPkg::*; ();

	localparam int ResetCycles  = 5;
	localparam int ResetTimeout = 20;
	localparam int RunCycles    = 4000;
	localparam int RunTimeout   = RunCycles + 100;

	logic        clk24m;
	logic        rst;
	cpuWrite_t   cpuWr;
	logic        vramDone;
	raster_t     raster;
	logic        frameStart;
	aaSpeed_t    aaSpeed;
	logic        aaDisable;
	spriteAttr_t sprite;
	fixAttr_t    fix;
	pbusWord_t   pbus;
	logic        pbusDrive;
	vramAddr_t   vramAddr;

	// Model state
	slotIdx_t  mSlot;
	vramAddr_t mAddr;
	vramAddr_t mMod;
	aaSpeed_t  mDiv;
	aaCount_t  mAa;
	pbusWord_t expPbus;
	logic      expDrive;

	`include "tbChecks.svh"

	lspcPbus uut (
		.clk24m     (clk24m),
		.rst        (rst),
		.cpuWr      (cpuWr),
		.vramDone   (vramDone),
		.raster     (raster),
		.frameStart (frameStart),
		.aaSpeed    (aaSpeed),
		.aaDisable  (aaDisable),
		.sprite     (sprite),
		.fix        (fix),
		.pbus       (pbus),
		.pbusDrive  (pbusDrive),
		.vramAddr   (vramAddr)
	);

	initial begin
		clk24m = 1'b0;
		forever #50 clk24m = ~clk24m;
	end

	// Expected bus word for one slot from the inputs seen at that edge
	function automatic pbusWord_t slotWord(input slotIdx_t s, input spriteAttr_t spr,
			input fixAttr_t fx, input raster_t ras, input aaCount_t aa, input logic aaOff);
		pbusWord_t   w;
		tile_t       t;
		raster_t     lineSum;
		spriteLine_t ln;
		// Next raster line plus sprite Y, wraps at 512
		lineSum = ras + 9'd1 + spr.y;
		ln = lineSum[3:0];
		if (spr.vflip) begin
			ln = ~ln;
		end
		t = spr.tile;
		if (spr.aa3 && !aaOff) begin
			t[2:0] = aa;
		end else if (spr.aa2 && !aaOff) begin
			t[1:0] = aa[1:0];
		end
		w = '0;
		case (s)
			SlotSprTile: begin
				w.high = {t[19:16], ln};
				w.low  = t[15:0];
			end
			SlotSprPal: begin
				w.high = spr.pal;
				w.low  = {7'd0, spr.y};
			end
			SlotFix: begin
				w.high = {4'd0, fx.pal};
				w.low  = {4'd0, fx.tile};
			end
			default: begin
				w = '0;
			end
		endcase
		return w;
	endfunction

	// Cycle model, reads the inputs present at each rising edge
	always @(posedge clk24m) begin
		if (rst) begin
			mSlot    = SlotSprTile;
			mAddr    = '0;
			mMod     = '0;
			mDiv     = '0;
			mAa      = '0;
			expPbus  = '0;
			expDrive = 1'b0;
		end else begin
			// Output word uses the animation index from before this edge
			expPbus  = slotWord(mSlot, sprite, fix, raster, mAa, aaDisable);
			expDrive = (mSlot != SlotIdle);
			mSlot    = (mSlot == SlotIdle) ? SlotSprTile : slotIdx_t'(mSlot + 2'd1);
			// Address load beats the increment, increment uses the old modulo
			if (cpuWr.wrAddr) begin
				mAddr = cpuWr.data;
			end else if (vramDone) begin
				mAddr = mAddr + mMod;
			end
			if (cpuWr.wrMod) begin
				mMod = cpuWr.data;
			end
			if (frameStart) begin
				if (mDiv == aaSpeed) begin
					mDiv = '0;
					mAa  = mAa + 3'd1;
				end else begin
					mDiv = mDiv + 8'd1;
				end
			end
		end
	end

	// Polls for reset release on falling edges
	task automatic waitResetRelease(output logic released);
		int waited;
		released = 1'b0;
		waited   = 0;
		while (!released && waited < ResetTimeout) begin
			@(negedge clk24m);
			waited++;
			if (!rst) begin
				released = 1'b1;
			end
		end
		if (!released) begin
			$display("Reset was not released within %0d cycles", ResetTimeout);
			otherErrors++;
		end
	endtask

	initial begin
		logic        released;
		logic [31:0] rnd32;
		logic [63:0] rnd64;
		int          cyclesRun;
		int          guard;
		int          totalErrors;
		void'($urandom(22));
		rst        = 1'b1;
		cpuWr      = '0;
		vramDone   = 1'b0;
		raster     = '0;
		frameStart = 1'b0;
		rnd32      = $urandom % 4;
		aaSpeed    = rnd32[AaSpeedWidth-1:0];
		aaDisable  = 1'b0;
		sprite     = '0;
		fix        = '0;
		repeat (ResetCycles) @(posedge clk24m);
		rst <= 1'b0;
		waitResetRelease(released);
		cyclesRun = 0;
		guard     = 0;
		if (released) begin
			// First cycle after reset, everything still cleared
			checkPbus(pbus, '0);
			checkDrive(pbusDrive, 1'b0);
			checkVramAddr(vramAddr, '0);
			while (cyclesRun < RunCycles && guard < RunTimeout) begin
				@(posedge clk24m);
				rnd32 = $urandom;
				cpuWr <= {($urandom % 8) == 0, ($urandom % 8) == 0, rnd32[15:0]};
				vramDone   <= ($urandom % 4) == 0;
				frameStart <= ($urandom % 16) == 0;
				aaDisable  <= ($urandom % 4) == 0;
				rnd32 = $urandom;
				raster <= rnd32[RasterWidth-1:0];
				rnd64 = {$urandom, $urandom};
				sprite <= rnd64[$bits(spriteAttr_t)-1:0];
				rnd32 = $urandom;
				fix <= rnd32[$bits(fixAttr_t)-1:0];
				// Speed changes rarely so the divider gets to wrap
				if (($urandom % 128) == 0) begin
					rnd32 = $urandom % 4;
					aaSpeed <= rnd32[AaSpeedWidth-1:0];
				end
				@(negedge clk24m);
				guard++;
				checkPbus(pbus, expPbus);
				checkDrive(pbusDrive, expDrive);
				checkVramAddr(vramAddr, mAddr);
				cyclesRun++;
			end
			if (cyclesRun < RunCycles) begin
				$display("Run stopped after %0d of %0d cycles", cyclesRun, RunCycles);
				otherErrors++;
			end
		end
		totalErrors = pbusErrors + driveErrors + addrErrors + otherErrors;
		$display("Errors: pbus %0d, pbusDrive %0d, vramAddr %0d, other %0d",
			pbusErrors, driveErrors, addrErrors, otherErrors);
		if (totalErrors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/lspcPbus.sv
// LSPC P-bus word assembly, top level
// Slot sequencer, CPU VRAM address unit, auto-animation timer,
// sprite tile builder and the registered P-bus output mux
`timescale 1ns/1ps
`default_nettype none

module lspcPbus import lspcPkg::*; (
	input  logic        clk24m,
	input  logic        rst,
	input  cpuWrite_t   cpuWr,
	input  logic        vramDone,
	input  raster_t     raster,
	input  logic        frameStart,
	input  aaSpeed_t    aaSpeed,
	input  logic        aaDisable,
	input  spriteAttr_t sprite,
	input  fixAttr_t    fix,
	output pbusWord_t   pbus,
	output logic        pbusDrive,
	output vramAddr_t   vramAddr
);

	slotIdx_t    slot;
	logic        drive;
	aaCount_t    aaCount;
	tile_t       sprTile;
	spriteLine_t sprLine;

	// Bus slot rotation and drive decode
	pbusSequencer seq (
		.clk24m (clk24m),
		.rst    (rst),
		.slot   (slot),
		.drive  (drive)
	);

	// CPU VRAM address path
	vramAddrUnit vau (
		.clk24m   (clk24m),
		.rst      (rst),
		.cpuWr    (cpuWr),
		.vramDone (vramDone),
		.vramAddr (vramAddr)
	);

	autoAnimTimer aat (
		.clk24m     (clk24m),
		.rst        (rst),
		.frameStart (frameStart),
		.aaSpeed    (aaSpeed),
		.aaCount    (aaCount)
	);

	// Line number and animated tile index
	spriteTileBuilder stb (
		.sprite    (sprite),
		.raster    (raster),
		.aaCount   (aaCount),
		.aaDisable (aaDisable),
		.tileOut   (sprTile),
		.line      (sprLine)
	);

	pbusMux mux (
		.clk24m    (clk24m),
		.rst       (rst),
		.slot      (slot),
		.drive     (drive),
		.tile      (sprTile),
		.line      (sprLine),
		.sprite    (sprite),
		.fix       (fix),
		.pbus      (pbus),
		.pbusDrive (pbusDrive)
	);

endmodule

`default_nettype wire

//--- logic/pbusMux.sv
// P-bus output multiplexer
// Builds the word for the current slot and registers it, together
// with the upper-byte drive enable, onto the P bus outputs
`timescale 1ns/1ps
`default_nettype none

module pbusMux import lspcPkg::*; (
	input  logic        clk24m,
	input  logic        rst,
	input  slotIdx_t    slot,
	input  logic        drive,
	input  tile_t       tile,
	input  spriteLine_t line,
	input  spriteAttr_t sprite,
	input  fixAttr_t    fix,
	output pbusWord_t   pbus,
	output logic        pbusDrive
);

	pbusWord_t wordNext;

	// Slot word select
	always_comb begin
		case (slot)
			SlotSprTile: begin
				// Tile MSBs share the upper byte with the line number
				wordNext.high = {tile[TileWidth-1:PbusLowWidth], line};
				wordNext.low  = tile[PbusLowWidth-1:0];
			end
			SlotSprPal: begin
				wordNext.high = sprite.pal;
				wordNext.low  = PbusLowWidth'(sprite.y);
			end
			SlotFix: begin
				wordNext.high = PbusHighWidth'(fix.pal);
				wordNext.low  = PbusLowWidth'(fix.tile);
			end
			default: begin
				// Idle slot, bus parked at zero
				wordNext = '0;
			end
		endcase
	end

	// Output register, lags the slot by one cycle
	always_ff @(posedge clk24m) begin
		if (rst) begin
			pbus      <= '0;
			pbusDrive <= 1'b0;
		end else begin
			pbus      <= wordNext;
			pbusDrive <= drive;
		end
	end

	// Idle word and released upper byte come out together
	property pIdleRelease;
		@(posedge clk24m) disable iff (rst)
			(!$past(rst) && $past(slot) == SlotIdle) |-> (!pbusDrive && pbus == '0);
	endproperty
	aIdleRelease: assert property (pIdleRelease)
		else $error("P bus driven after idle slot");

endmodule

`default_nettype wire

//--- logic/spriteTileBuilder.sv
// Sprite tile word builder
// Works out the line inside the sprite from the lookahead raster and
// the sprite Y position, and substitutes auto-animation bits in the tile
`timescale 1ns/1ps
`default_nettype none

module spriteTileBuilder import lspcPkg::*; (
	input  spriteAttr_t sprite,
	input  raster_t     raster,
	input  aaCount_t    aaCount,
	input  logic        aaDisable,
	output tile_t       tileOut,
	output spriteLine_t line
);

	raster_t yLookahead;
	raster_t yAdd;
	logic    aa3En;
	logic    aa2Only;
	logic    aa2En;

	// Render one line ahead of the current raster
	assign yLookahead = raster + 1'b1;

	// Sum wraps at 512 lines
	assign yAdd = yLookahead + sprite.y;

	// Low nibble picks the line in the tile, mirrored under vflip
	assign line = yAdd[SpriteLineWidth-1:0] ^ {SpriteLineWidth{sprite.vflip}};

	// Auto-animation enables
	// 3-bit mode implies the 2-bit replacement too
	assign aa3En   = sprite.aa3 & ~aaDisable;
	assign aa2Only = sprite.aa2 & ~aaDisable;
	assign aa2En   = aa3En | aa2Only;

	always_comb begin
		tileOut = sprite.tile;
		if (aa3En) begin
			tileOut[2] = aaCount[2];
		end
		if (aa2En) begin
			tileOut[1:0] = aaCount[1:0];
		end
	end

endmodule

`default_nettype wire

//--- logic/autoAnimTimer.sv
// Sprite auto-animation timer
// Divides frame pulses by aaSpeed plus one and steps the
// 3-bit auto-animation tile index on each divider rollover
`timescale 1ns/1ps
`default_nettype none

module autoAnimTimer import lspcPkg::*; (
	input  logic     clk24m,
	input  logic     rst,
	input  logic     frameStart,
	input  aaSpeed_t aaSpeed,
	output aaCount_t aaCount
);

	aaSpeed_t frameDiv;
	logic     divWrap;

	// Rollover when the divider has reached the programmed speed
	assign divWrap = (frameDiv == aaSpeed);

	always_ff @(posedge clk24m) begin
		if (rst) begin
			frameDiv <= '0;
			aaCount  <= '0;
		end else if (frameStart) begin
			if (divWrap) begin
				frameDiv <= '0;
				// Index wraps modulo 8
				aaCount  <= aaCount + 1'b1;
			end else begin
				// Speed lowered below the count wraps through 255
				frameDiv <= frameDiv + 1'b1;
			end
		end
	end

	// Index moves only on the edge after a frame pulse
	property pAaStep;
		@(posedge clk24m) disable iff (rst)
			(!$past(rst) && !$stable(aaCount)) |-> $past(frameStart);
	endproperty
	aAaStep: assert property (pAaStep)
		else $error("aaCount changed without frameStart");

endmodule

`default_nettype wire

//--- logic/vramAddrUnit.sv
// CPU-side VRAM address unit
// Holds the VRAM address and modulo registers. The address is loaded by
// a CPU address write, or advanced by the modulo when a VRAM write completes
`timescale 1ns/1ps
`default_nettype none

module vramAddrUnit import lspcPkg::*; (
	input  logic      clk24m,
	input  logic      rst,
	input  cpuWrite_t cpuWr,
	input  logic      vramDone,
	output vramAddr_t vramAddr
);

	vramAddr_t modReg;
	vramAddr_t addrAutoInc;
	vramAddr_t addrNext;
	logic      addrUpdate;

	// Modulo register, new value only seen from the next edge
	always_ff @(posedge clk24m) begin
		if (rst) begin
			modReg <= '0;
		end else if (cpuWr.wrMod) begin
			modReg <= cpuWr.data;
		end
	end

	// Address plus modulo, wraps at 16 bits
	assign addrAutoInc = vramAddr + modReg;

	// Update type select
	// Direct load wins over the post-write increment
	assign addrNext   = cpuWr.wrAddr ? cpuWr.data : addrAutoInc;
	assign addrUpdate = cpuWr.wrAddr | vramDone;

	always_ff @(posedge clk24m) begin
		if (rst) begin
			vramAddr <= '0;
		end else if (addrUpdate) begin
			vramAddr <= addrNext;
		end
	end

	// No address movement without a load or a completed write
	property pAddrHold;
		@(posedge clk24m) disable iff (rst)
			(!$past(rst) && !$past(cpuWr.wrAddr) && !$past(vramDone))
				|-> $stable(vramAddr);
	endproperty
	aAddrHold: assert property (pAddrHold)
		else $error("vramAddr changed without wrAddr or vramDone");

endmodule

`default_nettype wire

//--- logic/pbusSequencer.sv
// P-bus slot sequencer
// Steps through the four bus slots, one per clock, and decodes
// the upper-byte drive enable for the current slot
`timescale 1ns/1ps
`default_nettype none

module pbusSequencer import lspcPkg::*; (
	input  logic     clk24m,
	input  logic     rst,
	output slotIdx_t slot,
	output logic     drive
);

	// Free-running slot counter, wraps 3 -> 0 on its own
	always_ff @(posedge clk24m) begin
		if (rst) begin
			slot <= SlotSprTile;
		end else begin
			slot <= slot + 1'b1;
		end
	end

	// Upper byte released only in the idle slot
	// Registered in the mux together with the word itself
	assign drive = (slot != SlotIdle);

	// Rotation must never skip or repeat a slot
	property pSlotStep;
		@(posedge clk24m) disable iff (rst)
			!$past(rst) |-> slot == slotIdx_t'($past(slot) + 1'b1);
	endproperty
	aSlotStep: assert property (pSlotStep)
		else $error("slot did not advance by one");

endmodule

`default_nettype wire

//--- logic/lspcPkg.sv
// LSPC P-bus shared definitions
// Slot codes, field widths and the packed payload words used by the
// sprite/fix P-bus word assembly and the CPU VRAM address path
`default_nettype none

package lspcPkg;

	// Four fixed bus slots, one per clock
	localparam int SlotCount = 4;
	typedef logic [$clog2(SlotCount)-1:0] slotIdx_t;

	localparam slotIdx_t SlotSprTile = 2'd0;
	localparam slotIdx_t SlotSprPal  = 2'd1;
	localparam slotIdx_t SlotFix     = 2'd2;
	localparam slotIdx_t SlotIdle    = 2'd3;

	// Field widths
	localparam int VramAddrWidth   = 16;
	localparam int RasterWidth     = 9;
	localparam int TileWidth       = 20;
	localparam int AaWidth         = 3;
	localparam int AaSpeedWidth    = 8;
	localparam int SpriteLineWidth = 4;
	localparam int SprPalWidth     = 8;
	localparam int FixTileWidth    = 12;
	localparam int FixPalWidth     = 4;
	localparam int PbusHighWidth   = 8;
	localparam int PbusLowWidth    = 16;

	typedef logic [VramAddrWidth-1:0]   vramAddr_t;
	typedef logic [RasterWidth-1:0]     raster_t;
	typedef logic [TileWidth-1:0]       tile_t;
	typedef logic [AaWidth-1:0]         aaCount_t;
	typedef logic [AaSpeedWidth-1:0]    aaSpeed_t;
	typedef logic [SpriteLineWidth-1:0] spriteLine_t;

	// CPU register write, address load or modulo load
	typedef struct packed {
		logic                     wrAddr;
		logic                     wrMod;
		logic [VramAddrWidth-1:0] data;
	} cpuWrite_t;

	// Sprite attributes as fetched from VRAM
	typedef struct packed {
		tile_t                  tile;
		logic [SprPalWidth-1:0] pal;
		logic [RasterWidth-1:0] y;
		logic                   vflip;
		// Auto-animation enables, 2 or 3 low tile bits
		logic                   aa2;
		logic                   aa3;
	} spriteAttr_t;

	typedef struct packed {
		logic [FixTileWidth-1:0] tile;
		logic [FixPalWidth-1:0]  pal;
	} fixAttr_t;

	// Upper byte is the bidirectional part of the P bus
	typedef struct packed {
		logic [PbusHighWidth-1:0] high;
		logic [PbusLowWidth-1:0]  low;
	} pbusWord_t;

endpackage

`default_nettype wire
